/* hw/cpuPkg.sv */
`default_nettype none

// shared types and encodings for the MIPS32 subset core
package cpuPkg;

	// data and address values
	typedef logic [31:0] word;
	// register index
	typedef logic [4:0] regNum;

	// boot address of the core
	localparam word resetVector = 32'hBFC00000;

	//////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////

	// primary opcodes, instr[31:26]
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opLui = 6'h0F;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2B;

	// function codes under opSpecial, instr[5:0]
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2A;

	//////////////////////////////////////////////////
	// control encodings
	//////////////////////////////////////////////////

	// alu function, lui shifts operand b up by 16
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOp;

	// source of an execute operand
	typedef enum logic [1:0] {
		fwdReg,
		fwdMem,
		fwdWb
	} fwdSel;

endpackage

`default_nettype wire

/* hw/pipeBus.sv */
`default_nettype none
`timescale 1ns/1ns

// decode to execute bundle
interface decodeExecBus;
	cpuPkg::word pc, rsValue, rtValue, immediate;
	cpuPkg::regNum rs, rt, rd;
	cpuPkg::aluOp aluCtl;
	logic aluSrcImm, regDst, regWrite, memToReg, memWrite;

	modport decode (output pc, rsValue, rtValue, immediate, rs, rt, rd,
		aluCtl, aluSrcImm, regDst, regWrite, memToReg, memWrite);
	modport exec (input pc, rsValue, rtValue, immediate, rs, rt, rd,
		aluCtl, aluSrcImm, regDst, regWrite, memToReg, memWrite);
endinterface

// execute to memory bundle
interface execMemBus;
	cpuPkg::word pc, aluResult, storeData;
	cpuPkg::regNum destReg;
	logic regWrite, memToReg, memWrite;

	modport exec (output pc, aluResult, storeData, destReg,
		regWrite, memToReg, memWrite);
	modport mem (input pc, aluResult, storeData, destReg,
		regWrite, memToReg, memWrite);
endinterface

`default_nettype wire

/* hw/regFile.sv */
`default_nettype none
`timescale 1ns/1ns

// 32 general registers, two reads and one write
module regFile (
	input wire clk,
	input wire cpuPkg::regNum readA,
	input wire cpuPkg::regNum readB,
	output cpuPkg::word dataA,
	output cpuPkg::word dataB,
	input wire writeEnable,
	input wire cpuPkg::regNum writeNum,
	input wire cpuPkg::word writeData
);
	cpuPkg::word regs [32];

	// $0 is never stored
	always_ff @(posedge clk) begin
		if (writeEnable && writeNum != '0) begin
			regs[writeNum] <= writeData;
		end
	end

	// $0 reads zero, a same-cycle write is passed straight through
	function automatic cpuPkg::word readPort(input cpuPkg::regNum num);
		if (num == '0) begin
			return '0;
		end
		if (writeEnable && writeNum == num) begin
			return writeData;
		end
		return regs[num];
	endfunction

	always_comb begin
		dataA = readPort(readA);
		dataB = readPort(readB);
	end
endmodule

`default_nettype wire

/* hw/fetchDecode.sv */
`default_nettype none
`timescale 1ns/1ns

// fetch and decode stages, branches resolve here
module fetchDecode #(
	parameter cpuPkg::word resetPc = cpuPkg::resetVector
) (
	input wire clk,
	input wire reset,
	output cpuPkg::word pc,
	input wire cpuPkg::word instr,
	input wire stall,
	input wire fwdDecA,
	input wire fwdDecB,
	input wire cpuPkg::word memResult,
	output logic branchDec,
	output cpuPkg::regNum rsDec,
	output cpuPkg::regNum rtDec,
	output cpuPkg::regNum rfReadA,
	output cpuPkg::regNum rfReadB,
	input wire cpuPkg::word rfDataA,
	input wire cpuPkg::word rfDataB,
	decodeExecBus.decode toExec
);
	cpuPkg::word instrDec, pcDec, pcNext, immDec;
	cpuPkg::word pcDecPlus4, branchTarget, jumpTarget, cmpA, cmpB;
	logic [5:0] opDec, fnDec;
	cpuPkg::aluOp aluCtlDec;
	logic aluSrcImmDec, regDstDec, regWriteDec, memToRegDec, memWriteDec;
	logic beqDec, bneDec, jumpDec, branchTaken;

	//////////////////////////////////////////////////
	// PC and IF/ID registers
	//////////////////////////////////////////////////

	// both hold while stalled
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= resetPc;
			instrDec <= '0;
		end else if (!stall) begin
			pc <= pcNext;
			instrDec <= instr;
		end
	end

	// pc of the decoded word, payload only
	always_ff @(posedge clk) begin
		if (!stall) begin
			pcDec <= pc;
		end
	end

	//////////////////////////////////////////////////
	// decoder
	//////////////////////////////////////////////////

	assign opDec = instrDec[31:26];
	assign fnDec = instrDec[5:0];
	assign rsDec = instrDec[25:21];
	assign rtDec = instrDec[20:16];
	// 16-bit immediate, sign extended
	assign immDec = {{16{instrDec[15]}}, instrDec[15:0]};

	// unknown words fall through as no-ops
	always_comb begin
		aluCtlDec = cpuPkg::aluAdd;
		aluSrcImmDec = 1'b0;
		regDstDec = 1'b0;
		regWriteDec = 1'b0;
		memToRegDec = 1'b0;
		memWriteDec = 1'b0;
		beqDec = 1'b0;
		bneDec = 1'b0;
		jumpDec = 1'b0;
		case (opDec)
			cpuPkg::opSpecial: begin
				regDstDec = 1'b1;
				regWriteDec = 1'b1;
				case (fnDec)
					cpuPkg::fnAddu: aluCtlDec = cpuPkg::aluAdd;
					cpuPkg::fnSubu: aluCtlDec = cpuPkg::aluSub;
					cpuPkg::fnAnd: aluCtlDec = cpuPkg::aluAnd;
					cpuPkg::fnOr: aluCtlDec = cpuPkg::aluOr;
					cpuPkg::fnSlt: aluCtlDec = cpuPkg::aluSlt;
					// sll $0 and friends write nothing
					default: regWriteDec = 1'b0;
				endcase
			end
			cpuPkg::opAddiu: begin
				aluSrcImmDec = 1'b1;
				regWriteDec = 1'b1;
			end
			cpuPkg::opLui: begin
				aluCtlDec = cpuPkg::aluLui;
				aluSrcImmDec = 1'b1;
				regWriteDec = 1'b1;
			end
			cpuPkg::opLw: begin
				aluSrcImmDec = 1'b1;
				regWriteDec = 1'b1;
				memToRegDec = 1'b1;
			end
			cpuPkg::opSw: begin
				aluSrcImmDec = 1'b1;
				memWriteDec = 1'b1;
			end
			cpuPkg::opBeq: beqDec = 1'b1;
			cpuPkg::opBne: bneDec = 1'b1;
			cpuPkg::opJ: jumpDec = 1'b1;
			default: ;
		endcase
	end

	assign branchDec = beqDec | bneDec;

	//////////////////////////////////////////////////
	// branch compare and next PC
	//////////////////////////////////////////////////

	assign rfReadA = rsDec;
	assign rfReadB = rtDec;
	// alu result of the memory stage may be newer than the register file
	assign cmpA = fwdDecA ? memResult : rfDataA;
	assign cmpB = fwdDecB ? memResult : rfDataB;
	assign branchTaken = (beqDec && cmpA == cmpB) || (bneDec && cmpA != cmpB);

	// targets are relative to the delay slot
	assign pcDecPlus4 = pcDec + 32'd4;
	assign branchTarget = pcDecPlus4 + {immDec[29:0], 2'b00};
	assign jumpTarget = {pcDecPlus4[31:28], instrDec[25:0], 2'b00};

	always_comb begin
		if (jumpDec) begin
			pcNext = jumpTarget;
		end else if (branchTaken) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pc + 32'd4;
		end
	end

	// bundle to execute, writes masked into a bubble on a stall
	assign toExec.pc = pcDec;
	assign toExec.rsValue = rfDataA;
	assign toExec.rtValue = rfDataB;
	assign toExec.immediate = immDec;
	assign toExec.rs = rsDec;
	assign toExec.rt = rtDec;
	assign toExec.rd = instrDec[15:11];
	assign toExec.aluCtl = aluCtlDec;
	assign toExec.aluSrcImm = aluSrcImmDec;
	assign toExec.regDst = regDstDec;
	assign toExec.regWrite = regWriteDec & ~stall;
	assign toExec.memToReg = memToRegDec & ~stall;
	assign toExec.memWrite = memWriteDec & ~stall;
endmodule

`default_nettype wire

/* hw/hazardUnit.sv */
`default_nettype none
`timescale 1ns/1ns

// stall detection and forwarding selects
module hazardUnit (
	input wire cpuPkg::regNum rsDec,
	input wire cpuPkg::regNum rtDec,
	input wire branchDec,
	input wire cpuPkg::regNum rsExec,
	input wire cpuPkg::regNum rtExec,
	input wire cpuPkg::regNum destExec,
	input wire regWriteExec,
	input wire memToRegExec,
	input wire cpuPkg::regNum destMem,
	input wire regWriteMem,
	input wire memToRegMem,
	input wire cpuPkg::regNum destWb,
	input wire regWriteWb,
	output logic stall,
	output logic flushExec,
	output logic fwdDecA,
	output logic fwdDecB,
	output cpuPkg::fwdSel fwdExecA,
	output cpuPkg::fwdSel fwdExecB
);
	logic execHitsDec, memHitsDec, loadStall, branchStall;

	// memory stage wins over writeback, $0 never forwards
	function automatic cpuPkg::fwdSel pickSource(input cpuPkg::regNum src);
		if (src != '0 && regWriteMem && destMem == src) begin
			return cpuPkg::fwdMem;
		end
		if (src != '0 && regWriteWb && destWb == src) begin
			return cpuPkg::fwdWb;
		end
		return cpuPkg::fwdReg;
	endfunction

	assign fwdExecA = pickSource(rsExec);
	assign fwdExecB = pickSource(rtExec);

	// branch compare only takes the memory stage alu result
	assign fwdDecA = rsDec != '0 && regWriteMem && destMem == rsDec;
	assign fwdDecB = rtDec != '0 && regWriteMem && destMem == rtDec;

	// producers that decode reads from
	assign execHitsDec = destExec != '0 && (destExec == rsDec || destExec == rtDec);
	assign memHitsDec = destMem != '0 && (destMem == rsDec || destMem == rtDec);

	// load in execute feeding the next instruction
	assign loadStall = memToRegExec && execHitsDec;
	// branch waits for any execute result and for a load still in memory
	assign branchStall = branchDec &&
		((regWriteExec && execHitsDec) || (memToRegMem && memHitsDec));

	assign stall = loadStall | branchStall;
	assign flushExec = stall;
endmodule

`default_nettype wire

/* hw/executeStage.sv */
`default_nettype none
`timescale 1ns/1ns

// ID/EX register, operand forwarding and alu
module executeStage (
	input wire clk,
	input wire reset,
	input wire flushExec,
	input wire cpuPkg::fwdSel fwdExecA,
	input wire cpuPkg::fwdSel fwdExecB,
	input wire cpuPkg::word memResult,
	input wire cpuPkg::word wbResult,
	decodeExecBus.exec fromDecode,
	execMemBus.exec toMem,
	output cpuPkg::regNum rsExec,
	output cpuPkg::regNum rtExec,
	output cpuPkg::regNum destExec,
	output logic regWriteExec,
	output logic memToRegExec
);
	cpuPkg::word pcEx, rsValueEx, rtValueEx, immEx;
	cpuPkg::word srcA, fwdB, srcB, aluResult;
	cpuPkg::regNum rdEx;
	cpuPkg::aluOp aluCtlEx;
	logic aluSrcImmEx, regDstEx, memWriteEx;

	//////////////////////////////////////////////////
	// ID/EX register
	//////////////////////////////////////////////////

	// flush turns the slot into a bubble
	always_ff @(posedge clk) begin
		if (reset || flushExec) begin
			regWriteExec <= 1'b0;
			memToRegExec <= 1'b0;
			memWriteEx <= 1'b0;
		end else begin
			regWriteExec <= fromDecode.regWrite;
			memToRegExec <= fromDecode.memToReg;
			memWriteEx <= fromDecode.memWrite;
		end
	end

	// payload, meaningless in a bubble
	always_ff @(posedge clk) begin
		pcEx <= fromDecode.pc;
		rsValueEx <= fromDecode.rsValue;
		rtValueEx <= fromDecode.rtValue;
		immEx <= fromDecode.immediate;
		rsExec <= fromDecode.rs;
		rtExec <= fromDecode.rt;
		rdEx <= fromDecode.rd;
		aluCtlEx <= fromDecode.aluCtl;
		aluSrcImmEx <= fromDecode.aluSrcImm;
		regDstEx <= fromDecode.regDst;
	end

	// operand muxes
	always_comb begin
		case (fwdExecA)
			cpuPkg::fwdMem: srcA = memResult;
			cpuPkg::fwdWb: srcA = wbResult;
			default: srcA = rsValueEx;
		endcase
		case (fwdExecB)
			cpuPkg::fwdMem: fwdB = memResult;
			cpuPkg::fwdWb: fwdB = wbResult;
			default: fwdB = rtValueEx;
		endcase
	end

	// immediate for I-type, forwarded rt otherwise
	assign srcB = aluSrcImmEx ? immEx : fwdB;

	// alu
	always_comb begin
		case (aluCtlEx)
			cpuPkg::aluSub: aluResult = srcA - srcB;
			cpuPkg::aluAnd: aluResult = srcA & srcB;
			cpuPkg::aluOr: aluResult = srcA | srcB;
			cpuPkg::aluSlt: aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
			cpuPkg::aluLui: aluResult = {srcB[15:0], 16'h0000};
			default: aluResult = srcA + srcB;
		endcase
	end

	// R-type writes rd, I-type writes rt
	assign destExec = regDstEx ? rdEx : rtExec;

	assign toMem.pc = pcEx;
	assign toMem.aluResult = aluResult;
	assign toMem.storeData = fwdB;
	assign toMem.destReg = destExec;
	assign toMem.regWrite = regWriteExec;
	assign toMem.memToReg = memToRegExec;
	assign toMem.memWrite = memWriteEx;
endmodule

`default_nettype wire

/* hw/memWriteback.sv */
`default_nettype none
`timescale 1ns/1ns

// memory access and writeback stages
module memWriteback (
	input wire clk,
	input wire reset,
	execMemBus.mem fromExec,
	output logic memWrite,
	output cpuPkg::word memAddr,
	output cpuPkg::word writeData,
	input wire cpuPkg::word readData,
	output cpuPkg::word memResult,
	output cpuPkg::regNum destMem,
	output logic regWriteMem,
	output logic memToRegMem,
	output logic wbRegWrite,
	output cpuPkg::regNum wbRegNum,
	output cpuPkg::word wbRegData,
	output cpuPkg::word wbPc
);
	cpuPkg::word pcMem, aluMem, storeMem, pcWb, aluWb, loadWb;
	logic regWriteWb, memToRegWb;

	//////////////////////////////////////////////////
	// EX/MEM register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			regWriteMem <= 1'b0;
			memToRegMem <= 1'b0;
			memWrite <= 1'b0;
		end else begin
			regWriteMem <= fromExec.regWrite;
			memToRegMem <= fromExec.memToReg;
			memWrite <= fromExec.memWrite;
		end
	end

	always_ff @(posedge clk) begin
		pcMem <= fromExec.pc;
		aluMem <= fromExec.aluResult;
		storeMem <= fromExec.storeData;
		destMem <= fromExec.destReg;
	end

	// data memory answers in the same cycle
	assign memAddr = aluMem;
	assign writeData = storeMem;
	// alu result only since loads are not ready for forwarding yet
	assign memResult = aluMem;

	//////////////////////////////////////////////////
	// MEM/WB register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			regWriteWb <= 1'b0;
		end else begin
			regWriteWb <= regWriteMem;
		end
	end

	always_ff @(posedge clk) begin
		memToRegWb <= memToRegMem;
		pcWb <= pcMem;
		aluWb <= aluMem;
		loadWb <= readData;
		wbRegNum <= destMem;
	end

	assign wbPc = pcWb;
	assign wbRegData = memToRegWb ? loadWb : aluWb;
	// writes to $0 are dropped here
	assign wbRegWrite = regWriteWb && wbRegNum != '0;
endmodule

`default_nettype wire

/* hw/mipsCore.sv */
`default_nettype none
`timescale 1ns/1ns

// five-stage MIPS32 subset core
module mipsCore #(
	parameter cpuPkg::word resetPc = cpuPkg::resetVector
) (
	input wire clk,
	input wire reset,
	output cpuPkg::word pc,
	input wire cpuPkg::word instr,
	output logic memWrite,
	output cpuPkg::word memAddr,
	output cpuPkg::word writeData,
	input wire cpuPkg::word readData,
	output cpuPkg::word wbPc,
	output logic wbRegWrite,
	output cpuPkg::regNum wbRegNum,
	output cpuPkg::word wbRegData
);
	cpuPkg::regNum rfReadA, rfReadB, rsDec, rtDec;
	cpuPkg::regNum rsExec, rtExec, destExec, destMem;
	cpuPkg::word rfDataA, rfDataB, memResult;
	cpuPkg::fwdSel fwdExecA, fwdExecB;
	logic stall, flushExec, fwdDecA, fwdDecB, branchDec;
	logic regWriteExec, memToRegExec, regWriteMem, memToRegMem;

	decodeExecBus decBus ();
	execMemBus exBus ();

	// register file, written from writeback
	regFile rf (
		.clk(clk), .readA(rfReadA), .readB(rfReadB),
		.dataA(rfDataA), .dataB(rfDataB),
		.writeEnable(wbRegWrite), .writeNum(wbRegNum), .writeData(wbRegData)
	);

	// input side
	fetchDecode #(.resetPc(resetPc)) front (
		.clk(clk), .reset(reset), .pc(pc), .instr(instr), .stall(stall),
		.fwdDecA(fwdDecA), .fwdDecB(fwdDecB), .memResult(memResult),
		.branchDec(branchDec), .rsDec(rsDec), .rtDec(rtDec),
		.rfReadA(rfReadA), .rfReadB(rfReadB), .rfDataA(rfDataA), .rfDataB(rfDataB),
		.toExec(decBus.decode)
	);

	hazardUnit hazard (
		.rsDec(rsDec), .rtDec(rtDec), .branchDec(branchDec),
		.rsExec(rsExec), .rtExec(rtExec), .destExec(destExec),
		.regWriteExec(regWriteExec), .memToRegExec(memToRegExec),
		.destMem(destMem), .regWriteMem(regWriteMem), .memToRegMem(memToRegMem),
		.destWb(wbRegNum), .regWriteWb(wbRegWrite),
		.stall(stall), .flushExec(flushExec), .fwdDecA(fwdDecA), .fwdDecB(fwdDecB),
		.fwdExecA(fwdExecA), .fwdExecB(fwdExecB)
	);

	// processing part
	executeStage exec (
		.clk(clk), .reset(reset), .flushExec(flushExec),
		.fwdExecA(fwdExecA), .fwdExecB(fwdExecB),
		.memResult(memResult), .wbResult(wbRegData),
		.fromDecode(decBus.exec), .toMem(exBus.exec),
		.rsExec(rsExec), .rtExec(rtExec), .destExec(destExec),
		.regWriteExec(regWriteExec), .memToRegExec(memToRegExec)
	);

	// output side
	memWriteback back (
		.clk(clk), .reset(reset), .fromExec(exBus.mem),
		.memWrite(memWrite), .memAddr(memAddr), .writeData(writeData),
		.readData(readData), .memResult(memResult), .destMem(destMem),
		.regWriteMem(regWriteMem), .memToRegMem(memToRegMem),
		.wbRegWrite(wbRegWrite), .wbRegNum(wbRegNum),
		.wbRegData(wbRegData), .wbPc(wbPc)
	);
endmodule

`default_nettype wire

/* verif/mipsCore_props.sv */
`default_nettype none
`timescale 1ns/1ns

// port level checks on the core
module mipsCoreProps (
	input wire clk,
	input wire reset,
	input wire cpuPkg::word pc,
	input wire memWrite,
	input wire cpuPkg::word memAddr,
	input wire wbRegWrite,
	input wire cpuPkg::regNum wbRegNum
);
	// fetch on word boundaries only
	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc is not word aligned");

	// bubbles everywhere once reset is seen
	noStoreInReset: assert property (@(posedge clk) reset |=> !memWrite)
		else $error("memWrite high during reset");

	// $0 writes are dropped before the port
	noWriteToZero: assert property (@(posedge clk) disable iff (reset)
		wbRegWrite |-> wbRegNum != 5'd0)
		else $error("writeback names register 0");

	// word stores only
	storeAligned: assert property (@(posedge clk) disable iff (reset)
		memWrite |-> memAddr[1:0] == 2'b00)
		else $error("store address is not word aligned");
endmodule

bind mipsCore mipsCoreProps props (
	.clk(clk), .reset(reset), .pc(pc), .memWrite(memWrite),
	.memAddr(memAddr), .wbRegWrite(wbRegWrite), .wbRegNum(wbRegNum)
);

`default_nettype wire

/* verif/mipsCoreTb.sv */
`default_nettype none
`timescale 1ns/1ns

module mipsCoreTb;
	localparam cpuPkg::word bootPc = cpuPkg::resetVector;
	localparam int imemWords = 128;
	localparam int dmemWords = 64;
	localparam int fileWords = 256;

	logic clk;
	logic reset;
	cpuPkg::word pc, instr, memAddr, writeData, readData;
	cpuPkg::word wbPc, wbRegData, pcOffset;
	logic memWrite, wbRegWrite;
	cpuPkg::regNum wbRegNum;

	// raw data file, then the two memories
	cpuPkg::word testData [fileWords];
	cpuPkg::word imem [imemWords];
	cpuPkg::word dmem [dmemWords];

	int progCount, traceCount, traceBase, traceIdx;
	int cycleCount, cycleLimit;
	logic traceDone;

	mipsCore #(.resetPc(bootPc)) dut (
		.clk(clk), .reset(reset), .pc(pc), .instr(instr),
		.memWrite(memWrite), .memAddr(memAddr), .writeData(writeData),
		.readData(readData), .wbPc(wbPc), .wbRegWrite(wbRegWrite),
		.wbRegNum(wbRegNum), .wbRegData(wbRegData)
	);

	// 20 ns period
	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// memory models
	//////////////////////////////////////////////////

	// instruction memory starts at the boot address, nop outside
	assign pcOffset = pc - bootPc;
	assign instr = (pcOffset < imemWords * 4) ? imem[pcOffset[8:2]] : 32'h0;

	// data memory, combinational read
	assign readData = dmem[memAddr[7:2]];

	// stores land at the clock edge
	always @(posedge clk) begin
		if (memWrite === 1'b1) begin
			dmem[memAddr[7:2]] <= writeData;
		end
	end

	//////////////////////////////////////////////////
	// failure handling and compare
	//////////////////////////////////////////////////

	task automatic abortRun(input string reason);
		$display("Simulation FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkValue(input cpuPkg::word actual, input cpuPkg::word expected,
		input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t writeback %0d %s: got %h, expected %h",
				$time, traceIdx, what, actual, expected);
			abortRun("writeback trace mismatch");
		end
	endtask

	// trace check at mid cycle, one triple per register write
	always @(negedge clk) begin
		if (!reset && !traceDone) begin
			if (wbRegWrite === 1'b1) begin
				checkValue({27'd0, wbRegNum}, testData[traceBase + 3 * traceIdx],
					"register number");
				checkValue(wbRegData, testData[traceBase + 3 * traceIdx + 1],
					"register value");
				checkValue(wbPc, testData[traceBase + 3 * traceIdx + 2], "writeback pc");
				traceIdx = traceIdx + 1;
				if (traceIdx == traceCount) begin
					traceDone = 1'b1;
				end
			end else if (wbRegWrite !== 1'b0) begin
				$display("writeback strobe is unknown at %0t", $time);
				abortRun("unknown writeback strobe");
			end
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int i;
		clk = 1'b0;
		reset = 1'b1;
		traceIdx = 0;
		traceDone = 1'b0;
		cycleCount = 0;
		$readmemh("verif/mipsCore_testdata.hex", testData);
		// header words first
		if ($isunknown(testData[0]) || $isunknown(testData[1])) begin
			$display("test data file is missing or has no header");
			abortRun("bad test data");
		end
		progCount = testData[0];
		traceCount = testData[1];
		traceBase = 2 + progCount;
		if (progCount > imemWords || traceCount == 0 ||
			traceBase + 3 * traceCount > fileWords) begin
			$display("test data header does not fit the memories");
			abortRun("bad test data");
		end
		cycleLimit = 2 * traceCount + 50;
		// program, rest of memory reads as nop
		for (i = 0; i < imemWords; i++) begin
			imem[i] = (i < progCount) ? testData[2 + i] : 32'h0;
		end
		// fill tied to the byte address
		for (i = 0; i < dmemWords; i++) begin
			dmem[i] = 32'hA5A50000 ^ (i << 2);
		end
		repeat (4) @(posedge clk);
		#2 reset = 1'b0;
		while (!traceDone && cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		if (traceDone) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("timeout after %0d cycles, %0d of %0d writebacks seen",
				cycleCount, traceIdx, traceCount);
			abortRun("timeout");
		end
	end
endmodule

`default_nettype wire

/* verif/mipsCore_testdata.hex */
// header: program word count, expected writeback count
// then program words, then per writeback: register, value, pc
0000001B 00000014
3C011234 24020056 00221825 2404FFFF 00622824 00443023 0082382A
0044402A 00E64821 240A0040 AD490004 8D4B0004 01616021 8D4D0004
240E0007 15A90002 240F0011 24100022 10450002 24110033 24120044
26330001 24000005 0BF0001A 24140055 24160077 24150066
01 12340000 BFC00000
02 00000056 BFC00004
03 12340056 BFC00008
04 FFFFFFFF BFC0000C
05 00000056 BFC00010
06 00000057 BFC00014
07 00000001 BFC00018
08 00000000 BFC0001C
09 00000058 BFC00020
0A 00000040 BFC00024
0B 00000058 BFC0002C
0C 12340058 BFC00030
0D 00000058 BFC00034
0E 00000007 BFC00038
0F 00000011 BFC00040
10 00000022 BFC00044
11 00000033 BFC0004C
13 00000034 BFC00054
14 00000055 BFC00060
15 00000066 BFC00068

/* compile.f */
hw/cpuPkg.sv
hw/pipeBus.sv
hw/regFile.sv
hw/fetchDecode.sv
hw/hazardUnit.sv
hw/executeStage.sv
hw/memWriteback.sv
hw/mipsCore.sv
verif/mipsCore_props.sv
verif/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - files:
      - hw/cpuPkg.sv
      - hw/pipeBus.sv
      - hw/regFile.sv
      - hw/fetchDecode.sv
      - hw/hazardUnit.sv
      - hw/executeStage.sv
      - hw/memWriteback.sv
      - hw/mipsCore.sv
  - target: test
    files:
      - verif/mipsCore_props.sv
      - verif/mipsCoreTb.sv
